//--- files.f
hdl/hit_pkg.sv
hdl/scan_timer.sv
hdl/object_request.sv
hdl/hit_detection.sv
hdl/apb_regs.sv
hdl/collision_top.sv
verif/collision_tb.sv

//--- hdl/apb_regs.sv
`timescale 1ns/1ps

module apb_regs (
	input  logic clk,
	input  logic resetN,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [7:0] paddr,
	input  logic [31:0] pwdata,
	input  logic start_of_frame,
	input  logic [hit_pkg::num_collisions-1:0] hit_pulse,
	output logic [31:0] prdata,
	output logic [hit_pkg::num_objects-1:0][31:0] obj_rects
);

	logic wr_en;
	logic aligned;
	logic obj_sel;
	logic cnt_sel;
	logic frame_sel;
	logic [7:0] obj_off;
	logic [7:0] cnt_off;
	logic [hit_pkg::num_collisions-1:0][hit_pkg::count_width-1:0] hit_count;
	logic [hit_pkg::count_width-1:0] frame_count;

	assign wr_en = psel && penable && pwrite; // last cycle of a write.
	assign aligned = (paddr[1:0] == 2'b00);
	assign obj_off = paddr - hit_pkg::addr_obj_base;
	assign cnt_off = paddr - hit_pkg::addr_cnt_base;

	assign obj_sel = aligned && (obj_off < 8'(4 * hit_pkg::num_objects));
	assign cnt_sel = aligned && (paddr >= hit_pkg::addr_cnt_base) &&
		(cnt_off < 8'(4 * hit_pkg::num_collisions));
	assign frame_sel = (paddr == hit_pkg::addr_frame);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			obj_rects <= '0;
		end else begin
			for (int k = 0; k < hit_pkg::num_objects; k++) begin
				if (wr_en && obj_sel && (obj_off[7:2] == 6'(k)))
					obj_rects[k] <= pwdata;
			end
		end
	end

	// a write clears the counter and wins over a pulse in the same cycle.
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			hit_count <= '0;
		end else begin
			for (int k = 0; k < hit_pkg::num_collisions; k++) begin
				if (wr_en && cnt_sel && (cnt_off[7:2] == 6'(k)))
					hit_count[k] <= '0;
				else if (hit_pulse[k] && (hit_count[k] != '1))
					hit_count[k] <= hit_count[k] + 1'b1; // saturating.
			end
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			frame_count <= '0;
		else if (wr_en && frame_sel)
			frame_count <= '0;
		else if (start_of_frame)
			frame_count <= frame_count + 1'b1;
	end

	always_comb begin
		prdata = '0; // unmapped reads return zero.
		if (obj_sel)
			prdata = obj_rects[obj_off[5:2]];
		else if (cnt_sel)
			prdata = 32'(hit_count[cnt_off[5:2]]);
		else if (frame_sel)
			prdata = 32'(frame_count);
	end

endmodule

//--- hdl/collision_top.sv
`timescale 1ns/1ps

module collision_top (
	input  logic clk,
	input  logic resetN,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [7:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic [hit_pkg::num_collisions-1:0] hit_pulse
);

	logic [hit_pkg::coord_width-1:0] col;
	logic [hit_pkg::coord_width-1:0] row;
	logic start_of_frame;
	logic [hit_pkg::num_objects-1:0][31:0] obj_rects;
	logic [hit_pkg::num_objects-1:0] hit_request;

	scan_timer scan_timer_i (
		.clk            (clk),
		.resetN         (resetN),
		.col            (col),
		.row            (row),
		.start_of_frame (start_of_frame)
	);

	object_request object_request_i (
		.clk         (clk),
		.resetN      (resetN),
		.col         (col),
		.row         (row),
		.obj_rects   (obj_rects),
		.hit_request (hit_request)
	);

	// pulses go to the counters and out to the score and sound logic.
	hit_detection hit_detection_i (
		.clk            (clk),
		.resetN         (resetN),
		.start_of_frame (start_of_frame),
		.hit_request    (hit_request),
		.hit_pulse      (hit_pulse)
	);

	apb_regs apb_regs_i (
		.clk            (clk),
		.resetN         (resetN),
		.psel           (psel),
		.penable        (penable),
		.pwrite         (pwrite),
		.paddr          (paddr),
		.pwdata         (pwdata),
		.start_of_frame (start_of_frame),
		.hit_pulse      (hit_pulse),
		.prdata         (prdata),
		.obj_rects      (obj_rects)
	);

endmodule

//--- hdl/hit_detection.sv
`timescale 1ns/1ps

module hit_detection (
	input  logic clk,
	input  logic resetN,
	input  logic start_of_frame,
	input  logic [hit_pkg::num_objects-1:0] hit_request,
	output logic [hit_pkg::num_collisions-1:0] hit_pulse
);

	logic enemy_missile;
	logic player_missile;
	logic any_missile;
	logic edge_boundary;
	logic all_boundaries;
	logic player;
	logic gift;
	logic constrained_enemies;
	logic unconstrained_enemies;
	logic any_enemy;
	logic [hit_pkg::num_collisions-1:0] collision;
	logic [hit_pkg::num_collisions-1:0] flags; // types already reported this frame.
	logic [hit_pkg::num_collisions-1:0] live_flags;

	assign enemy_missile = hit_request[hit_pkg::obj_enemy_missile_a] |
		hit_request[hit_pkg::obj_enemy_missile_b];
	assign player_missile = hit_request[hit_pkg::obj_player_missile];
	assign any_missile = enemy_missile | player_missile;
	assign edge_boundary = hit_request[hit_pkg::obj_edge_boundary];
	assign all_boundaries = edge_boundary | hit_request[hit_pkg::obj_middle_boundary];
	assign player = hit_request[hit_pkg::obj_player];
	assign gift = hit_request[hit_pkg::obj_gift];
	assign constrained_enemies = hit_request[hit_pkg::obj_monster] |
		hit_request[hit_pkg::obj_boss];
	assign unconstrained_enemies = hit_request[hit_pkg::obj_asteroid];
	assign any_enemy = constrained_enemies | unconstrained_enemies;

	assign collision[hit_pkg::col_enemy_missile] = any_enemy & player_missile;
	assign collision[hit_pkg::col_enemy_any_boundary] = constrained_enemies & all_boundaries;
	assign collision[hit_pkg::col_missile_far_boundary] = any_missile & edge_boundary;
	assign collision[hit_pkg::col_player_any_boundary] = player & all_boundaries;
	assign collision[hit_pkg::col_player_missile] = player & enemy_missile;
	assign collision[hit_pkg::col_enemy_far_boundary] = unconstrained_enemies & edge_boundary;
	assign collision[hit_pkg::col_player_enemy] = player & any_enemy;
	assign collision[hit_pkg::col_player_gift] = player & gift;
	assign collision[hit_pkg::col_gift_boundary] = gift & edge_boundary;

	// flags drop at frame start, so a collision in that cycle reports again.
	assign live_flags = start_of_frame ? '0 : flags;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			flags <= '0;
			hit_pulse <= '0;
		end else begin
			hit_pulse <= collision & ~live_flags;
			flags <= live_flags | collision;
		end
	end

endmodule

//--- hdl/hit_pkg.sv
package hit_pkg;

	// bit positions of the objects in the draw request vector.
	localparam int num_objects = 10;
	localparam int obj_edge_boundary = 0;
	localparam int obj_middle_boundary = 1;
	localparam int obj_player = 2;
	localparam int obj_player_missile = 3;
	localparam int obj_monster = 4;
	localparam int obj_enemy_missile_a = 5;
	localparam int obj_asteroid = 6;
	localparam int obj_boss = 7;
	localparam int obj_enemy_missile_b = 8;
	localparam int obj_gift = 9;

	// bit positions of the collision types in the hit pulse vector.
	localparam int num_collisions = 9;
	localparam int col_enemy_missile = 0;
	localparam int col_enemy_any_boundary = 1;
	localparam int col_missile_far_boundary = 2;
	localparam int col_player_any_boundary = 3;
	localparam int col_player_missile = 4;
	localparam int col_enemy_far_boundary = 5;
	localparam int col_player_enemy = 6;
	localparam int col_player_gift = 7;
	localparam int col_gift_boundary = 8;

	// visible size of the reduced screen and its totals with blanking.
	localparam int h_active = 64;
	localparam int v_active = 48;
	localparam int h_total = 80;
	localparam int v_total = 56;

	localparam int coord_width = 8;
	localparam int count_width = 16;

	// register map in byte addresses with a four-byte stride.
	localparam logic [7:0] addr_obj_base = 8'h00;
	localparam logic [7:0] addr_cnt_base = 8'h40;
	localparam logic [7:0] addr_frame = 8'h64;

endpackage

//--- hdl/object_request.sv
`timescale 1ns/1ps

module object_request (
	input  logic clk,
	input  logic resetN,
	input  logic [hit_pkg::coord_width-1:0] col,
	input  logic [hit_pkg::coord_width-1:0] row,
	input  logic [hit_pkg::num_objects-1:0][31:0] obj_rects,
	output logic [hit_pkg::num_objects-1:0] hit_request
);

	logic visible;
	logic [hit_pkg::num_objects-1:0] req_next;

	assign visible = (col < hit_pkg::coord_width'(hit_pkg::h_active)) &&
		(row < hit_pkg::coord_width'(hit_pkg::v_active));

	for (genvar k = 0; k < hit_pkg::num_objects; k++) begin : g_obj
		logic [hit_pkg::coord_width-1:0] x, y, w, h;
		logic [hit_pkg::coord_width:0] x_end; // one extra bit so x plus w cannot wrap.
		logic [hit_pkg::coord_width:0] y_end;
		logic in_x;
		logic in_y;

		assign x = obj_rects[k][31:24];
		assign y = obj_rects[k][23:16];
		assign w = obj_rects[k][15:8];
		assign h = obj_rects[k][7:0];
		assign x_end = {1'b0, x} + {1'b0, w};
		assign y_end = {1'b0, y} + {1'b0, h};

		// an empty span fails the upper bound by itself.
		assign in_x = (col >= x) && ({1'b0, col} < x_end);
		assign in_y = (row >= y) && ({1'b0, row} < y_end);
		assign req_next[k] = visible && in_x && in_y;
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			hit_request <= '0;
		else
			hit_request <= req_next;
	end

endmodule

//--- hdl/scan_timer.sv
`timescale 1ns/1ps

module scan_timer (
	input  logic clk,
	input  logic resetN,
	output logic [hit_pkg::coord_width-1:0] col,
	output logic [hit_pkg::coord_width-1:0] row,
	output logic start_of_frame
);

	logic col_wrap;
	logic row_wrap;

	assign col_wrap = (col == hit_pkg::coord_width'(hit_pkg::h_total - 1));
	assign row_wrap = (row == hit_pkg::coord_width'(hit_pkg::v_total - 1));

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			col <= '0;
			row <= '0;
		end else begin
			if (col_wrap) begin
				col <= '0;
				row <= row_wrap ? '0 : row + 1'b1; // row moves once per line.
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	// one cycle at the screen origin.
	assign start_of_frame = (col == '0) && (row == '0);

endmodule

//--- run.sh
#!/bin/sh
# build and run the collision testbench with Verilator
verilator --binary --timing --top-module collision_tb -f files.f -o collision_sim \
	&& ./obj_dir/collision_sim > sim.log 2>&1
cat sim.log
grep -q "^all tests passed$" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- verif/collision_tb.sv
`timescale 1ns/1ps

module collision_tb;

	localparam int max_ops = 128;
	localparam int frame_cycles = hit_pkg::h_total * hit_pkg::v_total;

	logic clk;
	logic resetN;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic [hit_pkg::num_collisions-1:0] hit_pulse;

	logic [79:0] ops [0:max_ops-1]; // op, test, addr, data, expected.
	string test_names [0:5];
	int errors;
	int passed;
	int failed;
	int cur_test;
	int cycles;
	int limit;
	logic [31:0] lfsr_state;
	logic sof_d;
	logic [hit_pkg::num_collisions-1:0] seen;

	collision_top collision_top_i (
		.clk       (clk),
		.resetN    (resetN),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.hit_pulse (hit_pulse)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		lfsr_step = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// one lfsr step per address bit.
	task automatic random_addr(output logic [7:0] a);
		for (int i = 0; i < 8; i++) begin
			a[i] = lfsr_state[0];
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	function automatic logic is_mapped(input logic [7:0] a);
		is_mapped = (a[1:0] == 2'b00) && ((a < 8'h28) || ((a >= 8'h40) && (a <= 8'h64)));
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Error %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic apb_write(input logic [7:0] a, input logic [31:0] d);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= a;
		pwdata <= d;
		@(posedge clk);
		penable <= 1'b1; // write lands on the next edge.
	endtask

	task automatic apb_read(input logic [7:0] a, output logic [31:0] d);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= a;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		d = prdata;
	endtask

	task automatic apb_idle();
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	// frames are counted through the frame register.
	task automatic wait_frames(input logic [15:0] n);
		logic [31:0] start;
		logic [31:0] now;
		logic [15:0] diff;
		apb_read(hit_pkg::addr_frame, start);
		diff = 16'd0;
		while (diff < n) begin
			apb_read(hit_pkg::addr_frame, now);
			diff = now[15:0] - start[15:0];
		end
	endtask

	task automatic finish_test(input int idx);
		if (errors == 0) begin
			$display("test %s: ok", test_names[idx]);
			passed++;
		end else begin
			$display("test %s: %0d errors", test_names[idx], errors);
			failed++;
		end
		errors = 0;
	endtask

	// a new frame of pulses opens the cycle after start_of_frame.
	always @(negedge clk) begin
		cycles++;
		if (resetN) begin
			if (sof_d)
				seen = '0;
			if ((hit_pulse & seen) != '0) begin
				$display("hit_pulse %b pulsed twice in one frame during test %s",
					hit_pulse & seen, test_names[cur_test]);
				errors++;
			end
			if ((cur_test == 0) && (hit_pulse != '0)) begin
				$display("hit_pulse %b went high with no objects placed during test %s",
					hit_pulse, test_names[cur_test]);
				errors++;
			end
			seen = seen | hit_pulse;
			sof_d = collision_top_i.start_of_frame;
		end
		if (cycles >= limit) begin
			$display("timeout after %0d cycles", cycles);
			$display("tests failed");
			$finish;
		end
	end

	initial begin
		logic [3:0] op;
		logic [31:0] rd;
		logic [7:0] a;
		int wait_total;
		int other_ops;
		clk = 1'b0;
		resetN = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		lfsr_state = 32'h6cbf;
		errors = 0;
		passed = 0;
		failed = 0;
		cycles = 0;
		seen = '0;
		sof_d = 1'b0;
		wait_total = 0;
		other_ops = 0;
		limit = 1000;
		test_names[0] = "reset";
		test_names[1] = "readback";
		test_names[2] = "single_pulse";
		test_names[3] = "collision_types";
		test_names[4] = "disabled";
		test_names[5] = "counter_clear";
		for (int k = 0; k < max_ops; k++)
			ops[k] = '0;
		$readmemh("verif/collision_trace.txt", ops);
		for (int k = 0; k < max_ops; k++) begin
			if (ops[k][79:76] == 4'd3)
				wait_total += int'(ops[k][63:32]);
			else if (ops[k][79:76] != 4'd0)
				other_ops++;
		end
		limit = wait_total * frame_cycles + 2 * other_ops + 1000;
		cur_test = int'(ops[0][75:72]);
		repeat (8) @(posedge clk);
		resetN <= 1'b1;
		for (int k = 0; k < max_ops; k++) begin
			op = ops[k][79:76];
			if (op == 4'd0)
				break;
			if (int'(ops[k][75:72]) != cur_test) begin
				finish_test(cur_test);
				cur_test = int'(ops[k][75:72]);
			end
			case (op)
				4'd1: apb_write(ops[k][71:64], ops[k][63:32]);
				4'd2: begin
					apb_read(ops[k][71:64], rd);
					check(test_names[cur_test], ops[k][31:0], rd);
				end
				4'd3: wait_frames(ops[k][47:32]);
				4'd4: begin
					for (int j = 0; j < int'(ops[k][63:32]); j++) begin
						do
							random_addr(a);
						while (is_mapped(a));
						apb_read(a, rd);
						check(test_names[cur_test], 32'h0, rd);
					end
				end
				default: begin
					$display("unknown opcode %h in trace line %0d", op, k);
					errors++;
				end
			endcase
		end
		finish_test(cur_test);
		apb_idle();
		$display("%0d tests ok, %0d tests with errors", passed, failed);
		if (failed == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- verif/collision_trace.txt
// op_test_addr_data_expected; op 1 write, 2 read, 3 wait data frames, 4 data random reads
// objects are x_y_w_h bytes; counters start at 40, frame count at 64
2_0_00_00000000_00000000
2_0_24_00000000_00000000
2_0_40_00000000_00000000
2_0_60_00000000_00000000
1_1_10_12345678_00000000
2_1_10_00000000_12345678
1_1_24_a5a5a5a5_00000000
2_1_24_00000000_a5a5a5a5
4_1_00_00000008_00000000
3_2_00_00000001_00000000
1_2_08_0a0a0808_00000000
1_2_14_0c0c0808_00000000
3_2_00_00000003_00000000
2_2_50_00000000_00000003
1_3_14_00000000_00000000
1_3_1c_0c0c0808_00000000
3_3_00_00000001_00000000
1_3_1c_00000000_00000000
1_3_24_0c0c0808_00000000
3_3_00_00000001_00000000
1_3_24_00000000_00000000
1_3_04_0c0c0808_00000000
3_3_00_00000001_00000000
1_3_08_00000000_00000000
1_3_10_0a0a0808_00000000
3_3_00_00000001_00000000
1_3_04_00000000_00000000
1_3_0c_0c0c0808_00000000
3_3_00_00000001_00000000
1_3_10_00000000_00000000
1_3_00_0a0a0808_00000000
3_3_00_00000001_00000000
1_3_0c_00000000_00000000
1_3_18_0c0c0808_00000000
3_3_00_00000001_00000000
1_3_18_00000000_00000000
1_3_24_0c0c0808_00000000
3_3_00_00000001_00000000
2_3_40_00000000_00000001
2_3_44_00000000_00000001
2_3_48_00000000_00000001
2_3_4c_00000000_00000001
2_3_50_00000000_00000003
2_3_54_00000000_00000001
2_3_58_00000000_00000001
2_3_5c_00000000_00000001
2_3_60_00000000_00000001
1_4_24_0c0c0800_00000000
3_4_00_00000001_00000000
2_4_60_00000000_00000001
1_5_44_00000000_00000000
2_5_44_00000000_00000000
2_5_40_00000000_00000001
1_5_64_00000000_00000000
3_5_00_00000002_00000000
2_5_64_00000000_00000002
